// File: verilog/archPkg.sv
`default_nettype none

package archPkg;

  // Register codes as they appear in opcode fields
  typedef enum logic [2:0] {
    regB   = 3'd0,
    regC   = 3'd1,
    regD   = 3'd2,
    regE   = 3'd3,
    regH   = 3'd4,
    regL   = 3'd5,
    regMem = 3'd6,
    regA   = 3'd7
  } regCodeT;

  // Opcode bits 5:3 of the 8x..Bx block
  typedef enum logic [2:0] {
    aluAdd, aluAdc, aluSub, aluSbc, aluAnd, aluXor, aluOr, aluCp
  } aluOpT;

  localparam int flagZ = 7;
  localparam int flagN = 6;
  localparam int flagH = 5;
  localparam int flagC = 4;

  localparam logic [7:0] flagsReset = 8'hB0;

  // Line 0 has the highest priority
  localparam int intLines = 4;
  localparam logic [intLines-1:0][15:0] intVector = {
    16'h0060, 16'h0050, 16'h0048, 16'h0040
  };

endpackage

`default_nettype wire

// File: verilog/uopPkg.sv
`default_nettype none

package uopPkg;

  // Micro-op commands
  typedef enum logic [3:0] {
    nop,
    readToReg,   // Bus byte into destination register
    loadTempLo,
    loadTempHi,
    writeMem,
    selAddrHl,
    selAddrPc,
    blockOp,     // LD r,r' or ALU A,r
    incDec,
    loadPc,      // PC takes the jump temporary
    setIme,
    clearIme,
    intJump
  } uopCmdT;

  // ccFalse ends only a conditional JP whose condition fails
  typedef enum logic [1:0] {
    eofNever,
    eofAlways,
    eofCcFalse
  } eofCondT;

  typedef struct packed {
    uopCmdT  cmd;
    logic    incPc;
    eofCondT eofCond;
  } uopT;

  typedef logic [4:0] uPcT;

  typedef enum logic [1:0] {
    afterReset,
    startFlow,
    runFlow,
    endFlow
  } flowStateT;

  // Flow start addresses in the micro-op ROM
  localparam uPcT flowNop     = 5'd0;
  localparam uPcT flowLdRn    = 5'd1;
  localparam uPcT flowBlock   = 5'd3;
  localparam uPcT flowIncDec  = 5'd4;
  localparam uPcT flowStoreHl = 5'd5;
  localparam uPcT flowJp      = 5'd8;
  localparam uPcT flowInt     = 5'd12;
  localparam uPcT flowEi      = 5'd13;
  localparam uPcT flowDi      = 5'd14;

endpackage

`default_nettype wire

// File: verilog/microcodeRom.sv
`timescale 1ns/1ps
`default_nettype none

module microcodeRom (
  input  wire uopPkg::uPcT uPc,
  input  wire [7:0]        fetchByte,
  output uopPkg::uopT      uop,
  output uopPkg::uPcT      flowIdx
);

  //----------------------------------------------------------------------
  // Micro-op table
  always_comb
  begin
    case (uPc)
      uopPkg::flowNop:          uop = '{uopPkg::nop, 1'b1, uopPkg::eofAlways};
      uopPkg::flowLdRn:         uop = '{uopPkg::nop, 1'b1, uopPkg::eofNever};
      uopPkg::flowLdRn + 5'd1:  uop = '{uopPkg::readToReg, 1'b1, uopPkg::eofAlways};
      uopPkg::flowBlock:        uop = '{uopPkg::blockOp, 1'b1, uopPkg::eofAlways};
      uopPkg::flowIncDec:       uop = '{uopPkg::incDec, 1'b1, uopPkg::eofAlways};
      uopPkg::flowStoreHl:      uop = '{uopPkg::selAddrHl, 1'b1, uopPkg::eofNever};
      uopPkg::flowStoreHl + 5'd1: uop = '{uopPkg::writeMem, 1'b0, uopPkg::eofNever};
      uopPkg::flowStoreHl + 5'd2: uop = '{uopPkg::selAddrPc, 1'b0, uopPkg::eofAlways};
      uopPkg::flowJp:           uop = '{uopPkg::nop, 1'b1, uopPkg::eofNever};
      uopPkg::flowJp + 5'd1:    uop = '{uopPkg::loadTempLo, 1'b1, uopPkg::eofNever};
      uopPkg::flowJp + 5'd2:    uop = '{uopPkg::loadTempHi, 1'b1, uopPkg::eofCcFalse};
      uopPkg::flowJp + 5'd3:    uop = '{uopPkg::loadPc, 1'b0, uopPkg::eofAlways};
      uopPkg::flowInt:          uop = '{uopPkg::intJump, 1'b0, uopPkg::eofAlways}; // No fetch
      uopPkg::flowEi:           uop = '{uopPkg::setIme, 1'b1, uopPkg::eofAlways};
      uopPkg::flowDi:           uop = '{uopPkg::clearIme, 1'b1, uopPkg::eofAlways};
      default:                  uop = '{uopPkg::nop, 1'b0, uopPkg::eofAlways};
    endcase
  end

  //----------------------------------------------------------------------
  // Opcode to flow
  always_comb
  begin
    flowIdx = uopPkg::flowNop;
    case (fetchByte[7:6])
      2'b00:
        if (fetchByte[5:3] != archPkg::regMem)
        begin
          if (fetchByte[2:0] == 3'b110)
            flowIdx = uopPkg::flowLdRn;
          else if (fetchByte[2:1] == 2'b10)
            flowIdx = uopPkg::flowIncDec;
        end
      2'b01:
        if (fetchByte[2:0] != archPkg::regMem)
        begin
          if (fetchByte[5:3] == archPkg::regMem)
            flowIdx = uopPkg::flowStoreHl;
          else
            flowIdx = uopPkg::flowBlock;
        end
      2'b10:
        if (fetchByte[2:0] != archPkg::regMem && fetchByte[5:3] != archPkg::aluAdc &&
            fetchByte[5:3] != archPkg::aluSbc)
          flowIdx = uopPkg::flowBlock;
      default:
        case (fetchByte)
          8'hC3, 8'hC2, 8'hCA, 8'hD2, 8'hDA: flowIdx = uopPkg::flowJp;
          8'hFB: flowIdx = uopPkg::flowEi;
          8'hF3: flowIdx = uopPkg::flowDi;
          default: flowIdx = uopPkg::flowNop;
        endcase
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/flowSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module flowSequencer (
  input  wire              iClock,
  input  wire              arstN,
  input  wire uopPkg::uPcT flowIdx,
  input  wire              intPending,
  input  wire uopPkg::uopT uop,
  input  wire [7:0]        flags,
  input  wire [7:0]        memRdData,
  output uopPkg::uPcT      uPc,
  output logic [7:0]       opcode,
  output logic             flowEnable,
  output logic             flowStart
);

  uopPkg::flowStateT state;
  logic ccHolds;
  logic eof;

  // Jump condition from opcode bits 4:3
  always_comb
  begin
    case (opcode[4:3])
      2'b00:   ccHolds = !flags[archPkg::flagZ];
      2'b01:   ccHolds = flags[archPkg::flagZ];
      2'b10:   ccHolds = !flags[archPkg::flagC];
      default: ccHolds = flags[archPkg::flagC];
    endcase
  end

  always_comb
  begin
    case (uop.eofCond)
      uopPkg::eofAlways:  eof = 1'b1;
      uopPkg::eofCcFalse: eof = !opcode[0] && !ccHolds; // C3 never ends early
      default:            eof = 1'b0;
    endcase
  end

  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
    begin
      state <= uopPkg::afterReset;
      uPc   <= '0;
    end
    else
    begin
      case (state)
        uopPkg::afterReset:
          state <= uopPkg::startFlow;
        uopPkg::startFlow:
        begin
          uPc   <= intPending ? uopPkg::flowInt : flowIdx;
          state <= uopPkg::runFlow;
        end
        uopPkg::runFlow:
        begin
          uPc <= uPc + 5'd1;
          if (eof)
            state <= uopPkg::endFlow;
        end
        default:
          state <= uopPkg::startFlow;
      endcase
    end
  end

  always_ff @(posedge iClock)
  begin
    if (state == uopPkg::startFlow)
      opcode <= memRdData;
  end

  assign flowEnable = (state == uopPkg::runFlow);
  assign flowStart  = (state == uopPkg::startFlow);

  upcHoldsOutsideFlow: assert property (@(posedge iClock) disable iff (!arstN)
    (state == uopPkg::endFlow || state == uopPkg::afterReset) |=> $stable(uPc));

endmodule

`default_nettype wire

// File: verilog/interruptControl.sv
`timescale 1ns/1ps
`default_nettype none

module interruptControl (
  input  wire                         iClock,
  input  wire                         arstN,
  input  wire [archPkg::intLines-1:0] intRequest,
  input  wire                         imeSet,
  input  wire                         imeClear,
  input  wire                         intTake,
  output logic                        intPending,
  output logic [15:0]                 intVectorAddr
);

  logic [archPkg::intLines-1:0]         latched;
  logic [$clog2(archPkg::intLines)-1:0] sel;
  logic                                 ime;

  // Lowest latched line wins
  always_comb
  begin
    sel = '0;
    for (int i = archPkg::intLines - 1; i >= 0; i--)
    begin
      if (latched[i])
        sel = $clog2(archPkg::intLines)'(i);
    end
  end

  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
    begin
      latched <= '0;
      ime     <= 1'b0;
    end
    else
    begin
      latched <= latched | intRequest;
      if (intTake)
        latched[sel] <= intRequest[sel]; // Held level latches again
      if (intTake || imeClear)
        ime <= 1'b0;
      else if (imeSet)
        ime <= 1'b1;
    end
  end

  assign intPending    = ime && (|latched);
  assign intVectorAddr = archPkg::intVector[sel];

  takeOnlyWhenPending: assert property (@(posedge iClock) disable iff (!arstN)
    intTake |-> intPending);

endmodule

`default_nettype wire

// File: verilog/uopDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module uopDecoder (
  input  wire              iClock,
  input  wire              arstN,
  input  wire uopPkg::uopT uop,
  input  wire [7:0]        opcode,
  input  wire              flowEnable,
  output logic             regWe,
  output archPkg::regCodeT regDst,
  output logic             regWrFromMem,
  output archPkg::regCodeT regSrc,
  output logic             flagWe,
  output logic             tempLoLoad,
  output logic             tempHiLoad,
  output logic             pcInc,
  output logic             pcLoad,
  output logic             pcVectorLoad,
  output logic             addrSelHl,
  output logic             memWe,
  output logic             imeSet,
  output logic             imeClear,
  output logic             intTake
);

  logic isAlu;
  logic isCp;

  assign isAlu = (opcode[7:6] == 2'b10);
  assign isCp  = isAlu && (opcode[5:3] == archPkg::aluCp);

  // ALU results always land in A
  assign regDst = (uop.cmd == uopPkg::blockOp && isAlu) ? archPkg::regA
                                                        : archPkg::regCodeT'(opcode[5:3]);
  assign regSrc = (uop.cmd == uopPkg::incDec) ? archPkg::regCodeT'(opcode[5:3])
                                              : archPkg::regCodeT'(opcode[2:0]);

  always_comb
  begin
    regWe        = 1'b0;
    regWrFromMem = 1'b0;
    flagWe       = 1'b0;
    tempLoLoad   = 1'b0;
    tempHiLoad   = 1'b0;
    pcInc        = 1'b0;
    pcLoad       = 1'b0;
    pcVectorLoad = 1'b0;
    memWe        = 1'b0;
    imeSet       = 1'b0;
    imeClear     = 1'b0;
    intTake      = 1'b0;
    if (flowEnable)
    begin
      pcInc = uop.incPc;
      case (uop.cmd)
        uopPkg::readToReg:
        begin
          regWe        = 1'b1;
          regWrFromMem = 1'b1;
        end
        uopPkg::blockOp:
        begin
          regWe  = !isCp;  // CP only compares
          flagWe = isAlu;
        end
        uopPkg::incDec:
        begin
          regWe  = 1'b1;
          flagWe = 1'b1;
        end
        uopPkg::loadTempLo: tempLoLoad = 1'b1;
        uopPkg::loadTempHi: tempHiLoad = 1'b1;
        uopPkg::writeMem:   memWe = 1'b1;
        uopPkg::loadPc:     pcLoad = 1'b1;
        uopPkg::setIme:     imeSet = 1'b1;
        uopPkg::clearIme:   imeClear = 1'b1;
        uopPkg::intJump:
        begin
          pcVectorLoad = 1'b1;
          intTake      = 1'b1;
        end
        default:
          regWe = 1'b0;
      endcase
    end
  end

  // Address select, PC unless a store is in progress
  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
      addrSelHl <= 1'b0;
    else if (flowEnable && uop.cmd == uopPkg::selAddrHl)
      addrSelHl <= 1'b1;
    else if (flowEnable && uop.cmd == uopPkg::selAddrPc)
      addrSelHl <= 1'b0;
  end

  noWriteWhileRegWrite: assert property (@(posedge iClock) disable iff (!arstN)
    !(memWe && regWe));

  storeAddressedByHl: assert property (@(posedge iClock) disable iff (!arstN)
    memWe |-> addrSelHl);

endmodule

`default_nettype wire

// File: verilog/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile #(
  parameter logic [15:0] resetPc = 16'h0100
) (
  input  wire                   iClock,
  input  wire                   arstN,
  input  wire                   regWe,
  input  wire                   pcInc,
  input  wire                   pcLoad,
  input  wire                   pcVectorLoad,
  input  wire                   tempLoLoad,
  input  wire                   tempHiLoad,
  input  wire archPkg::regCodeT regDst,
  input  wire archPkg::regCodeT regSrc,
  input  wire                   regWrFromMem,
  input  wire [7:0]             memRdData,
  input  wire [7:0]             aluResult,
  input  wire [7:0]             newFlags,
  input  wire                   flagWe,
  input  wire [15:0]            intVectorAddr,
  input  wire                   addrSelHl,
  output logic [7:0]            srcData,
  output logic [7:0]            regA,
  output logic [7:0]            flags,
  output logic [15:0]           memAddr,
  output logic [7:0]            memWrData
);

  logic [7:0]  gpr [0:5];  // B, C, D, E, H, L
  logic [15:0] pc;
  logic [15:0] temp;       // Jump target
  logic [7:0]  wrData;

  assign wrData = regWrFromMem ? memRdData : aluResult;

  //----------------------------------------------------------------------
  // Architectural state
  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < 6; i++)
        gpr[i] <= 8'h00;
      regA  <= 8'h00;
      flags <= archPkg::flagsReset;
      pc    <= resetPc;
      temp  <= 16'h0000;
    end
    else
    begin
      if (regWe && regDst == archPkg::regA)
        regA <= wrData;
      else if (regWe && regDst != archPkg::regMem)
        gpr[regDst] <= wrData;
      if (flagWe)
        flags <= newFlags;
      if (tempLoLoad)
        temp[7:0] <= memRdData;
      if (tempHiLoad)
        temp[15:8] <= memRdData;
      // Vector entry wins over a jump
      if (pcVectorLoad)
        pc <= intVectorAddr;
      else if (pcLoad)
        pc <= temp;
      else if (pcInc)
        pc <= pc + 16'd1;
    end
  end

  //----------------------------------------------------------------------
  // Read and address muxes
  always_comb
  begin
    case (regSrc)
      archPkg::regA:   srcData = regA;
      archPkg::regMem: srcData = 8'h00;  // No (HL) operand is kept
      default:         srcData = gpr[regSrc];
    endcase
  end

  assign memAddr   = addrSelHl ? {gpr[archPkg::regH], gpr[archPkg::regL]} : pc;
  assign memWrData = srcData;

endmodule

`default_nettype wire

// File: verilog/aluFlags.sv
`timescale 1ns/1ps
`default_nettype none

module aluFlags (
  input  wire [7:0]  opcode,
  input  wire [7:0]  operand,
  input  wire [7:0]  regA,
  input  wire [7:0]  flags,
  output logic [7:0] aluResult,
  output logic [7:0] newFlags
);

  logic [8:0] sum;
  logic [8:0] diff;
  logic [4:0] halfSum;
  logic       halfBorrow;
  logic       n;
  logic       h;
  logic       c;

  assign sum        = {1'b0, regA} + {1'b0, operand};
  assign diff       = {1'b0, regA} - {1'b0, operand};
  assign halfSum    = {1'b0, regA[3:0]} + {1'b0, operand[3:0]};
  assign halfBorrow = regA[3:0] < operand[3:0];  // Borrow from bit 4

  always_comb
  begin
    aluResult = operand;  // LD passes through
    n         = flags[archPkg::flagN];
    h         = flags[archPkg::flagH];
    c         = flags[archPkg::flagC];
    if (opcode[7:6] == 2'b10)
    begin
      case (archPkg::aluOpT'(opcode[5:3]))
        archPkg::aluAdd:
        begin
          aluResult = sum[7:0];
          n         = 1'b0;
          h         = halfSum[4];
          c         = sum[8];
        end
        archPkg::aluSub, archPkg::aluCp:
        begin
          aluResult = diff[7:0];
          n         = 1'b1;
          h         = halfBorrow;
          c         = diff[8];
        end
        archPkg::aluAnd:
        begin
          aluResult = regA & operand;
          {n, h, c} = 3'b010;
        end
        archPkg::aluXor:
        begin
          aluResult = regA ^ operand;
          {n, h, c} = 3'b000;
        end
        archPkg::aluOr:
        begin
          aluResult = regA | operand;
          {n, h, c} = 3'b000;
        end
        default:
          aluResult = operand;  // ADC and SBC are not decoded
      endcase
    end
    else if (opcode[7:6] == 2'b00 && opcode[2:1] == 2'b10)
    begin
      // INC and DEC keep C
      if (!opcode[0])
      begin
        aluResult = operand + 8'd1;
        n         = 1'b0;
        h         = (aluResult[3:0] == 4'h0);
      end
      else
      begin
        aluResult = operand - 8'd1;
        n         = 1'b1;
        h         = (aluResult[3:0] == 4'hF);
      end
    end
  end

  always_comb
  begin
    newFlags                 = 8'h00;
    newFlags[archPkg::flagZ] = (aluResult == 8'h00);
    newFlags[archPkg::flagN] = n;
    newFlags[archPkg::flagH] = h;
    newFlags[archPkg::flagC] = c;
  end

endmodule

`default_nettype wire

// File: verilog/gbCore.sv
`timescale 1ns/1ps
`default_nettype none

module gbCore #(
  parameter logic [15:0] resetPc = 16'h0100
) (
  input  wire                         iClock,
  input  wire                         arstN,
  input  wire [7:0]                   memRdData,
  input  wire [archPkg::intLines-1:0] intRequest,
  output logic [15:0]                 memAddr,
  output logic [7:0]                  memWrData,
  output logic                        memWe
);

  uopPkg::uPcT      uPc;
  uopPkg::uPcT      flowIdx;
  uopPkg::uopT      uop;
  logic [7:0]       opcode;
  logic             flowEnable;
  logic             flowStart;
  logic             regWe;
  logic             regWrFromMem;
  archPkg::regCodeT regDst;
  archPkg::regCodeT regSrc;
  logic             flagWe;
  logic             tempLoLoad;
  logic             tempHiLoad;
  logic             pcInc;
  logic             pcLoad;
  logic             pcVectorLoad;
  logic             addrSelHl;
  logic             imeSet;
  logic             imeClear;
  logic             intTake;
  logic [7:0]       srcData;
  logic [7:0]       regA;
  logic [7:0]       flags;
  logic [7:0]       aluResult;
  logic [7:0]       newFlags;
  logic             intPending;
  logic [15:0]      intVectorAddr;

  //----------------------------------------------------------------------
  // Control
  flowSequencer flowSequencer_i (
    .iClock     (iClock),
    .arstN      (arstN),
    .flowIdx    (flowIdx),
    .intPending (intPending),
    .uop        (uop),
    .flags      (flags),
    .memRdData  (memRdData),
    .uPc        (uPc),
    .opcode     (opcode),
    .flowEnable (flowEnable),
    .flowStart  (flowStart)
  );

  microcodeRom microcodeRom_i (
    .uPc       (uPc),
    .fetchByte (memRdData),
    .uop       (uop),
    .flowIdx   (flowIdx)
  );

  uopDecoder uopDecoder_i (
    .iClock       (iClock),
    .arstN        (arstN),
    .uop          (uop),
    .opcode       (opcode),
    .flowEnable   (flowEnable),
    .regWe        (regWe),
    .regDst       (regDst),
    .regWrFromMem (regWrFromMem),
    .regSrc       (regSrc),
    .flagWe       (flagWe),
    .tempLoLoad   (tempLoLoad),
    .tempHiLoad   (tempHiLoad),
    .pcInc        (pcInc),
    .pcLoad       (pcLoad),
    .pcVectorLoad (pcVectorLoad),
    .addrSelHl    (addrSelHl),
    .memWe        (memWe),
    .imeSet       (imeSet),
    .imeClear     (imeClear),
    .intTake      (intTake)
  );

  interruptControl interruptControl_i (
    .iClock        (iClock),
    .arstN         (arstN),
    .intRequest    (intRequest),
    .imeSet        (imeSet),
    .imeClear      (imeClear),
    .intTake       (intTake),
    .intPending    (intPending),
    .intVectorAddr (intVectorAddr)
  );

  //----------------------------------------------------------------------
  // Datapath
  registerFile #(
    .resetPc (resetPc)
  ) registerFile_i (
    .iClock        (iClock),
    .arstN         (arstN),
    .regWe         (regWe),
    .pcInc         (pcInc),
    .pcLoad        (pcLoad),
    .pcVectorLoad  (pcVectorLoad),
    .tempLoLoad    (tempLoLoad),
    .tempHiLoad    (tempHiLoad),
    .regDst        (regDst),
    .regSrc        (regSrc),
    .regWrFromMem  (regWrFromMem),
    .memRdData     (memRdData),
    .aluResult     (aluResult),
    .newFlags      (newFlags),
    .flagWe        (flagWe),
    .intVectorAddr (intVectorAddr),
    .addrSelHl     (addrSelHl),
    .srcData       (srcData),
    .regA          (regA),
    .flags         (flags),
    .memAddr       (memAddr),
    .memWrData     (memWrData)
  );

  aluFlags aluFlags_i (
    .opcode    (opcode),
    .operand   (srcData),
    .regA      (regA),
    .flags     (flags),
    .aluResult (aluResult),
    .newFlags  (newFlags)
  );

  // Every flow hands the bus back to PC before the next fetch
  fetchFromPc: assert property (@(posedge iClock) disable iff (!arstN)
    flowStart |-> !addrSelHl);

endmodule

`default_nettype wire

// File: test/gbCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module gbCoreTb;

  localparam logic [15:0] resetPc = 16'h0150;
  localparam int programs = 6;
  localparam int bodyLen = 48;
  localparam int drainLimit = 20000;
  localparam int refStepLimit = 4000;

  logic        iClock = 1'b0;
  logic        arstN;
  logic [7:0]  memRdData;
  logic [3:0]  intRequest;
  logic [15:0] memAddr;
  logic [7:0]  memWrData;
  logic        memWe;

  logic [7:0]  mem [0:65535];
  logic [7:0]  refMem [0:65535];
  logic [15:0] genPc;
  logic [15:0] expAddr [$];
  logic [7:0]  expData [$];
  logic [15:0] wantAddr;
  logic [7:0]  wantData;
  bit          running = 1'b0;

  gbCore #(
    .resetPc (resetPc)
  ) gbCore_i (
    .iClock     (iClock),
    .arstN      (arstN),
    .memRdData  (memRdData),
    .intRequest (intRequest),
    .memAddr    (memAddr),
    .memWrData  (memWrData),
    .memWe      (memWe)
  );

  always #2 iClock = ~iClock;

  // Combinational memory, sampled on the falling edge
  always @(negedge iClock)
  begin
    if (memWe)
      mem[memAddr] = memWrData;
    memRdData = mem[memAddr];
  end

  //--------------------------------------------------------------------
  // Compare tasks
  task automatic checkAddr(input logic [15:0] got, input logic [15:0] want);
    if (got !== want)
    begin
      $display("[FAIL] memAddr got %h expected %h", got, want);
      $display("Simulation failed");
      $fatal(1, "Address mismatch");
    end
  endtask

  task automatic checkData(input logic [7:0] got, input logic [7:0] want);
    if (got !== want)
    begin
      $display("[FAIL] memWrData got %h expected %h", got, want);
      $display("Simulation failed");
      $fatal(1, "Data mismatch");
    end
  endtask

  task automatic checkStrobe(input logic got, input logic want);
    if (got !== want)
    begin
      $display("[FAIL] memWe got %h expected %h", got, want);
      $display("Simulation failed");
      $fatal(1, "Strobe mismatch");
    end
  endtask

  // Write stream against the reference queue
  always @(negedge iClock)
  begin
    if (running && memWe)
    begin
      if (expAddr.size() == 0)
      begin
        $display("Unexpected write to %h with data %h", memAddr, memWrData);
        $display("Simulation failed");
        $fatal(1, "Extra write");
      end
      else
      begin
        wantAddr = expAddr.pop_front();
        wantData = expData.pop_front();
        checkAddr(memAddr, wantAddr);
        checkData(memWrData, wantData);
      end
    end
  end

  //--------------------------------------------------------------------
  // Program generator
  task automatic putByte(input logic [7:0] b);
    mem[genPc] = b;
    genPc = genPc + 16'd1;
  endtask

  // Any register but (HL), optionally not H
  function automatic int randomReg(input bit allowH);
    int r;
    r = 6;
    while (r == 6 || (!allowH && r == 4))
      r = int'($urandom % 8);
    return r;
  endfunction

  task automatic buildProgram();
    int          aluOps [6] = '{0, 2, 4, 5, 6, 7};
    int          kind;
    int          d;
    int          s;
    logic [15:0] a16;
    logic [15:0] v;
    logic [15:0] tgt;
    for (int a = 0; a < 65536; a++)
    begin
      a16 = 16'(a);
      mem[a16] = a16[15:8] ^ a16[7:0] ^ 8'h3C;
    end
    // Vector handlers: store B, C, D or E, then spin
    for (int k = 0; k < archPkg::intLines; k++)
    begin
      v = archPkg::intVector[k];
      tgt = v + 16'd1;
      mem[v] = {5'b01110, 3'(k)};
      mem[v + 16'd1] = 8'hC3;
      mem[v + 16'd2] = tgt[7:0];
      mem[v + 16'd3] = tgt[15:8];
    end
    genPc = resetPc;
    for (int r = 0; r < 8; r++)
    begin
      if (r != 6)
        putByte({5'b01110, 3'(r)});  // Registers straight out of reset
    end
    putByte(8'h26);
    putByte(8'h80 | 8'($urandom));  // H stays in the upper half
    for (int i = 0; i < bodyLen; i++)
    begin
      kind = int'($urandom % 8);
      case (kind)
        0:
        begin
          d = randomReg(1'b0);
          putByte({2'b00, 3'(d), 3'b110});
          putByte(8'($urandom));
        end
        1:
        begin
          d = randomReg(1'b0);
          s = randomReg(1'b1);
          putByte({2'b01, 3'(d), 3'(s)});
        end
        2:
          putByte({5'b01110, 3'(randomReg(1'b1))});
        3, 4, 5:
        begin
          if (kind == 5)
            putByte({2'b00, 3'(randomReg(1'b0)), 2'b10, 1'($urandom % 2)});
          else
            putByte({2'b10, 3'(aluOps[$urandom % 6]), 3'(randomReg(1'b1))});
          // JP cc over LD (HL),A
          tgt = genPc + 16'd4;
          putByte({3'b110, 2'($urandom % 4), 3'b010});
          putByte(tgt[7:0]);
          putByte(tgt[15:8]);
          putByte(8'h77);
        end
        6:
        begin
          tgt = genPc + 16'd4;
          putByte(8'hC3);
          putByte(tgt[7:0]);
          putByte(tgt[15:8]);
          putByte({5'b01110, 3'(randomReg(1'b1))});  // Never reached
        end
        default:
        begin
          case ($urandom % 4)
            0:       putByte(8'h00);
            1:       putByte(8'hF3);
            2:       putByte(8'h76);
            default: putByte(8'hCB);
          endcase
        end
      endcase
    end
    // Distinct B to E so each vector's store names its line
    for (int k = 0; k < archPkg::intLines; k++)
    begin
      putByte({2'b00, 3'(k), 3'b110});
      putByte(8'hA0 + 8'(k));
    end
    putByte(8'hFB);
    tgt = genPc;
    putByte(8'hC3);
    putByte(tgt[7:0]);
    putByte(tgt[15:8]);
  endtask

  //--------------------------------------------------------------------
  // Reference ISA model
  function automatic void aluStep(input logic [7:0] op, input logic [7:0] a,
                                  input logic [7:0] b, input logic [7:0] fIn,
                                  output logic [7:0] res, output logic [7:0] fOut);
    logic n;
    logic h;
    logic c;
    n = fIn[archPkg::flagN];
    h = fIn[archPkg::flagH];
    c = fIn[archPkg::flagC];
    res = b;
    if (op[7:6] == 2'b10)
    begin
      case (op[5:3])
        3'd0:
        begin
          res = a + b;
          n = 1'b0;
          h = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'h0F;
          c = ({1'b0, a} + {1'b0, b}) > 9'h0FF;
        end
        3'd2, 3'd7:
        begin
          res = a - b;
          n = 1'b1;
          h = ({1'b0, a[3:0]} - {1'b0, b[3:0]}) > 5'h0F;
          c = a < b;
        end
        3'd4:
        begin
          res = a & b;
          n = 1'b0;
          h = 1'b1;
          c = 1'b0;
        end
        3'd5:
        begin
          res = a ^ b;
          n = 1'b0;
          h = 1'b0;
          c = 1'b0;
        end
        default:
        begin
          res = a | b;
          n = 1'b0;
          h = 1'b0;
          c = 1'b0;
        end
      endcase
    end
    else if (!op[0])
    begin
      res = b + 8'd1;
      n = 1'b0;
      h = (res[3:0] == 4'h0);
    end
    else
    begin
      res = b - 8'd1;
      n = 1'b1;
      h = (res[3:0] == 4'hF);
    end
    fOut = {res == 8'h00, n, h, c, 4'h0};
  endfunction

  function automatic void refRun(input logic [3:0] req);
    logic [7:0]  r [0:7];
    logic [7:0]  f;
    logic [7:0]  fNew;
    logic [7:0]  res;
    logic [7:0]  op;
    logic [15:0] pc;
    logic [15:0] tgt;
    logic        ime;
    logic        cond;
    bit          done;
    int          steps;
    for (int i = 0; i < 8; i++)
      r[i] = 8'h00;
    f = archPkg::flagsReset;
    pc = resetPc;
    ime = 1'b0;
    done = 1'b0;
    steps = 0;
    tgt = 16'h0000;
    while (!done && steps < refStepLimit)
    begin
      steps++;
      if (ime && req != 4'b0000)
      begin
        for (int k = archPkg::intLines - 1; k >= 0; k--)
        begin
          if (req[k])
            tgt = archPkg::intVector[k];
        end
        pc = tgt;
        ime = 1'b0;
      end
      else
      begin
        op = refMem[pc];
        case (op[7:6])
          2'b00:
          begin
            if (op[5:3] != 3'd6 && op[2:0] == 3'b110)
            begin
              r[op[5:3]] = refMem[pc + 16'd1];
              pc = pc + 16'd2;
            end
            else
            begin
              if (op[5:3] != 3'd6 && op[2:1] == 2'b10)
              begin
                aluStep(op, r[7], r[op[5:3]], f, res, fNew);
                r[op[5:3]] = res;
                f = fNew;
              end
              pc = pc + 16'd1;
            end
          end
          2'b01:
          begin
            if (op[2:0] != 3'd6 && op[5:3] == 3'd6)
            begin
              expAddr.push_back({r[4], r[5]});
              expData.push_back(r[op[2:0]]);
              refMem[{r[4], r[5]}] = r[op[2:0]];
            end
            else if (op[2:0] != 3'd6)
              r[op[5:3]] = r[op[2:0]];
            pc = pc + 16'd1;
          end
          2'b10:
          begin
            if (op[2:0] != 3'd6 && op[5:3] != 3'd1 && op[5:3] != 3'd3)
            begin
              aluStep(op, r[7], r[op[2:0]], f, res, fNew);
              f = fNew;
              if (op[5:3] != 3'd7)
                r[7] = res;  // CP keeps A
            end
            pc = pc + 16'd1;
          end
          default:
          begin
            if (op == 8'hC3 || op == 8'hC2 || op == 8'hCA || op == 8'hD2 || op == 8'hDA)
            begin
              tgt = {refMem[pc + 16'd2], refMem[pc + 16'd1]};
              case (op[4:3])
                2'b00:   cond = !f[archPkg::flagZ];
                2'b01:   cond = f[archPkg::flagZ];
                2'b10:   cond = !f[archPkg::flagC];
                default: cond = f[archPkg::flagC];
              endcase
              if (op == 8'hC3)
                cond = 1'b1;
              if (op == 8'hC3 && tgt == pc)
                done = 1'b1;  // Final spin loop
              else
                pc = cond ? tgt : pc + 16'd3;
            end
            else
            begin
              if (op == 8'hFB)
                ime = 1'b1;
              else if (op == 8'hF3)
                ime = 1'b0;
              pc = pc + 16'd1;
            end
          end
        endcase
      end
    end
    if (!done)
    begin
      $display("Reference model never reached the final loop");
      $display("Simulation failed");
      $fatal(1, "Reference runaway");
    end
  endfunction

  //--------------------------------------------------------------------
  initial
  begin
    int         seedDummy;
    int         waitCycles;
    logic [3:0] req;
    seedDummy = $urandom(32'haac4_76b0);
    arstN = 1'b0;
    memRdData = 8'h00;
    intRequest = 4'b0000;
    for (int p = 0; p < programs; p++)
    begin
      // First program runs without requests
      req = (p == 0) ? 4'b0000 : 4'(($urandom % 15) + 1);
      @(negedge iClock);
      running = 1'b0;
      arstN = 1'b0;
      intRequest = req;
      buildProgram();
      refMem = mem;
      refRun(req);
      repeat (5)
      begin
        @(negedge iClock);
        checkStrobe(memWe, 1'b0);
        checkAddr(memAddr, resetPc);
      end
      arstN = 1'b1;
      running = 1'b1;
      repeat (2)
      begin
        @(negedge iClock);
        checkStrobe(memWe, 1'b0);
        checkAddr(memAddr, resetPc);  // First fetch and its first micro-op
      end
      waitCycles = 0;
      while (expAddr.size() != 0)
      begin
        @(posedge iClock);
        waitCycles++;
        if (waitCycles > drainLimit)
        begin
          $display("Timeout with %0d expected writes still missing", expAddr.size());
          $display("Simulation failed");
          $fatal(1, "Write stream incomplete");
        end
      end
      repeat (200) @(negedge iClock);  // Watch for extra writes
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
verilog/archPkg.sv
verilog/uopPkg.sv
verilog/microcodeRom.sv
verilog/flowSequencer.sv
verilog/interruptControl.sv
verilog/uopDecoder.sv
verilog/registerFile.sv
verilog/aluFlags.sv
verilog/gbCore.sv
test/gbCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build gbCoreTb with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f --top-module gbCoreTb \
    -Mdir obj_dir -o gbCoreSim; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/gbCoreSim; then
  echo "Run returned a failing status"
  exit 1
fi

exit 0
